/* corr_cfg.svh */
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

// --------------------
// Array size
// --------------------

// Antennas per sample word, one bit each
`define CORR_ANTENNAS 24

// Signed width of each cos and sin accumulator
`define CORR_ACCUM_BITS 12

// Antenna pairs, also the slots per sample
`define CORR_PAIRS 12

// --------------------
// Pair table
// --------------------

// Entry k holds b index over a index in bits 10k+9 to 10k
// Listed from entry 11 down to entry 0
`define CORR_PAIR_TABLE { \
   5'd21, 5'd18, 5'd22, 5'd15, 5'd17, 5'd13, \
   5'd20, 5'd10, 5'd9,  5'd8,  5'd12, 5'd6,  \
   5'd23, 5'd5,  5'd11, 5'd4,  5'd7,  5'd3,  \
   5'd2,  5'd1,  5'd2,  5'd0,  5'd1,  5'd0 }

`endif

/* corr_pkg.sv */
`include "corr_cfg.svh"

package corr_pkg;

   // --------------------
   // Sample side
   // --------------------

   // One bit per antenna
   typedef logic [`CORR_ANTENNAS-1:0] ant_word_t;

   // Real and imaginary words of one sample
   typedef struct packed {
      ant_word_t re;
      ant_word_t im;
   } sample_t;

   // Pair index, 0 to 11
   typedef logic [$clog2(`CORR_PAIRS)-1:0] slot_t;

   // Antenna index into an ant_word_t
   typedef logic [$clog2(`CORR_ANTENNAS)-1:0] ant_idx_t;

   // Same layout as a pair table entry, b in the upper half
   typedef struct packed {
      ant_idx_t b_idx;
      ant_idx_t a_idx;
   } pair_t;

   // --------------------
   // Visibility side
   // --------------------

   // Wraps in two's complement
   typedef logic signed [`CORR_ACCUM_BITS-1:0] acc_t;

   // Sin above cos, as in the store
   typedef struct packed {
      acc_t sin_acc;
      acc_t cos_acc;
   } vis_t;

   // One slot on its way into the MAC
   typedef struct packed {
      logic    valid;
      logic    bank;
      slot_t   slot;
      sample_t sample;
   } slot_op_t;

   // Table entry for a slot
   function automatic pair_t pair_lookup(slot_t slot);
      logic [$bits(pair_t)*`CORR_PAIRS-1:0] table_bits;
      table_bits = `CORR_PAIR_TABLE;
      return pair_t'(table_bits[$bits(pair_t)*slot +: $bits(pair_t)]);
   endfunction

endpackage

/* corr_sample_capture.sv */
`include "corr_cfg.svh"

module corr_sample_capture (
   input  logic               clk_x,
   input  logic               arst_n,
   input  logic               sample_en,
   input  corr_pkg::sample_t  sample,
   input  logic               bank_swap,
   input  logic               pipe_busy,
   output logic               busy,
   output corr_pkg::slot_op_t slot_op,
   output logic               swap_now,
   output logic               bank_sel
);

   localparam corr_pkg::slot_t LAST_SLOT = corr_pkg::slot_t'(`CORR_PAIRS - 1);

   typedef enum logic {IDLE, RUN} cap_state_t;

   cap_state_t        state;
   corr_pkg::slot_t   slot_cnt;
   corr_pkg::sample_t smp_q;
   logic              swap_pend;
   logic              take;

   // Pending swap also holds off new samples
   assign busy = (state == RUN) || swap_pend;
   assign take = sample_en && !busy;

   // Swap only once the slot pass and the MAC are both empty
   assign swap_now = (state == IDLE) && swap_pend && !pipe_busy;

   // --------------------
   // Slot sequencer
   // --------------------

   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         slot_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (take) begin
                  state    <= RUN;
                  slot_cnt <= '0;
               end
            end
            RUN: begin
               // One pair per clock, back to idle after slot 11
               if (slot_cnt == LAST_SLOT) begin
                  state <= IDLE;
               end else begin
                  slot_cnt <= slot_cnt + 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Sample word held for the whole pass
   always_ff @(posedge clk_x) begin
      if (take) begin
         smp_q <= sample;
      end
   end

   // --------------------
   // Bank control
   // --------------------

   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         swap_pend <= 1'b0;
         bank_sel  <= 1'b0;
      end else begin
         // A pulse on the applying edge merges into this swap
         if (swap_now) begin
            swap_pend <= 1'b0;
            bank_sel  <= ~bank_sel;
         end else if (bank_swap) begin
            swap_pend <= 1'b1;
         end
      end
   end

   // Each slot is stamped with the bank it belongs to
   always_comb begin
      slot_op.valid  = (state == RUN);
      slot_op.bank   = bank_sel;
      slot_op.slot   = slot_cnt;
      slot_op.sample = smp_q;
   end

endmodule

/* corr_pair_mac.sv */
`include "corr_cfg.svh"

module corr_pair_mac (
   input  logic               clk_x,
   input  logic               arst_n,
   input  corr_pkg::slot_op_t slot_op,
   output logic               pipe_busy,
   output logic               rd_en,
   output logic               rd_bank,
   output corr_pkg::slot_t    rd_slot,
   input  corr_pkg::vis_t     rd_vis,
   output logic               wr_en,
   output logic               wr_bank,
   output corr_pkg::slot_t    wr_slot,
   output corr_pkg::vis_t     wr_vis
);

   localparam corr_pkg::acc_t ACC_POS = corr_pkg::acc_t'(1);
   localparam corr_pkg::acc_t ACC_NEG = corr_pkg::acc_t'(-1);

   // Stage 1 payload, the three bits the products need
   typedef struct packed {
      logic            bank;
      corr_pkg::slot_t slot;
      logic            ar;
      logic            br;
      logic            bi;
   } s1_t;

   // Stage 2 payload, finished sums
   typedef struct packed {
      logic            bank;
      corr_pkg::slot_t slot;
      corr_pkg::vis_t  vis;
   } s2_t;

   corr_pkg::pair_t pair;
   s1_t             s1_d;
   s1_t             s1_q;
   s2_t             s2_q;
   logic            s1_valid;
   logic            s2_valid;
   corr_pkg::acc_t  cos_step;
   corr_pkg::acc_t  sin_step;

   // --------------------
   // Stage 1
   // --------------------

   assign pair = corr_pkg::pair_lookup(slot_op.slot);

   always_comb begin
      s1_d.bank = slot_op.bank;
      s1_d.slot = slot_op.slot;
      s1_d.ar   = slot_op.sample.re[pair.a_idx];
      s1_d.br   = slot_op.sample.re[pair.b_idx];
      s1_d.bi   = slot_op.sample.im[pair.b_idx];
   end

   // Store read issued with the slot, data back next cycle
   assign rd_en   = slot_op.valid;
   assign rd_bank = slot_op.bank;
   assign rd_slot = slot_op.slot;

   // --------------------
   // Stage 2
   // --------------------

   // 1-bit products as +1 or -1
   assign cos_step = (s1_q.ar == s1_q.br) ? ACC_POS : ACC_NEG;
   assign sin_step = (s1_q.ar == s1_q.bi) ? ACC_POS : ACC_NEG;

   always_ff @(posedge clk_x) begin
      s1_q <= s1_d;
      // Wraps at the accumulator width
      s2_q.bank        <= s1_q.bank;
      s2_q.slot        <= s1_q.slot;
      s2_q.vis.cos_acc <= rd_vis.cos_acc + cos_step;
      s2_q.vis.sin_acc <= rd_vis.sin_acc + sin_step;
   end

   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= slot_op.valid;
         s2_valid <= s1_valid;
      end
   end

   // --------------------
   // Stage 3
   // --------------------

   // Write lands on the third edge after issue
   assign wr_en   = s2_valid;
   assign wr_bank = s2_q.bank;
   assign wr_slot = s2_q.slot;
   assign wr_vis  = s2_q.vis;

   // Issue cycle is covered by the capture state itself
   assign pipe_busy = s1_valid | s2_valid;

endmodule

/* corr_vis_bank.sv */
`include "corr_cfg.svh"

module corr_vis_bank (
   input  logic            clk_x,
   input  logic            arst_n,
   input  logic            bank_sel,
   input  logic            swap_now,
   input  logic            rd_en,
   input  logic            rd_bank,
   input  corr_pkg::slot_t rd_slot,
   output corr_pkg::vis_t  rd_vis,
   input  logic            wr_en,
   input  logic            wr_bank,
   input  corr_pkg::slot_t wr_slot,
   input  corr_pkg::vis_t  wr_vis,
   input  corr_pkg::slot_t rb_slot,
   output corr_pkg::vis_t  rb_vis
);

   // Two banks of accumulators, plain inferred RAM
   corr_pkg::vis_t mem [2][`CORR_PAIRS];

   // Set flag means the entry reads as zero
   logic [1:0][`CORR_PAIRS-1:0] clr_flag;

   logic idle_bank;

   // Bus side always looks at the bank not being accumulated
   assign idle_bank = ~bank_sel;

   // --------------------
   // Accumulator port
   // --------------------

   always_ff @(posedge clk_x) begin
      if (wr_en) begin
         mem[wr_bank][wr_slot] <= wr_vis;
      end
   end

   // Registered read, zero on first access after a swap
   always_ff @(posedge clk_x) begin
      if (rd_en) begin
         if (clr_flag[rd_bank][rd_slot]) begin
            rd_vis <= '0;
         end else begin
            rd_vis <= mem[rd_bank][rd_slot];
         end
      end
   end

   // --------------------
   // Clear flags
   // --------------------

   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         clr_flag <= '1;
      end else begin
         if (wr_en) begin
            clr_flag[wr_bank][wr_slot] <= 1'b0;
         end
         // New active bank is the current idle one
         if (swap_now) begin
            clr_flag[idle_bank] <= '1;
         end
      end
   end

   // Readback of the idle bank
   assign rb_vis = clr_flag[idle_bank][rb_slot] ? '0 : mem[idle_bank][rb_slot];

endmodule

/* corr_readout.sv */
`include "corr_cfg.svh"

module corr_readout (
   input  logic            clk_x,
   input  logic            arst_n,
   input  logic            bus_req,
   input  corr_pkg::slot_t bus_addr,
   output logic            bus_ack,
   output corr_pkg::vis_t  bus_data,
   output corr_pkg::slot_t rb_slot,
   input  corr_pkg::vis_t  rb_vis
);

   typedef enum logic {WAIT_REQ, ACKED} rd_state_t;

   rd_state_t state;
   logic      addr_ok;

   // Address held stable by the master while req is high
   assign rb_slot = bus_addr;
   assign addr_ok = (bus_addr < `CORR_PAIRS);

   // --------------------
   // Four-phase handshake
   // --------------------

   always_ff @(posedge clk_x or negedge arst_n) begin
      if (!arst_n) begin
         state <= WAIT_REQ;
      end else begin
         case (state)
            WAIT_REQ: begin
               if (bus_req) begin
                  state <= ACKED;
               end
            end
            ACKED: begin
               // Ack drops once req is seen low
               if (!bus_req) begin
                  state <= WAIT_REQ;
               end
            end
            default: state <= WAIT_REQ;
         endcase
      end
   end

   assign bus_ack = (state == ACKED);

   // Data captured with the rising ack, frozen while ack is high
   always_ff @(posedge clk_x) begin
      if ((state == WAIT_REQ) && bus_req) begin
         bus_data <= addr_ok ? rb_vis : '0;
      end
   end

endmodule

/* corr_top.sv */
`include "corr_cfg.svh"

module corr_top (
   input  logic              clk_x,
   input  logic              arst_n,
   input  logic              sample_en,
   input  corr_pkg::sample_t sample,
   output logic              busy,
   input  logic              bank_swap,
   output logic              bank_sel,
   input  logic              bus_req,
   input  corr_pkg::slot_t   bus_addr,
   output logic              bus_ack,
   output corr_pkg::vis_t    bus_data
);

   // --------------------
   // Internal nets
   // --------------------

   corr_pkg::slot_op_t slot_op;
   logic               swap_now;
   logic               pipe_busy;

   // MAC to store
   logic               rd_en;
   logic               rd_bank;
   corr_pkg::slot_t    rd_slot;
   corr_pkg::vis_t     rd_vis;
   logic               wr_en;
   logic               wr_bank;
   corr_pkg::slot_t    wr_slot;
   corr_pkg::vis_t     wr_vis;

   // Readout to store
   corr_pkg::slot_t    rb_slot;
   corr_pkg::vis_t     rb_vis;

   corr_sample_capture u_capture (
      .clk_x     (clk_x),
      .arst_n    (arst_n),
      .sample_en (sample_en),
      .sample    (sample),
      .bank_swap (bank_swap),
      .pipe_busy (pipe_busy),
      .busy      (busy),
      .slot_op   (slot_op),
      .swap_now  (swap_now),
      .bank_sel  (bank_sel)
   );

   corr_pair_mac u_mac (
      .clk_x     (clk_x),
      .arst_n    (arst_n),
      .slot_op   (slot_op),
      .pipe_busy (pipe_busy),
      .rd_en     (rd_en),
      .rd_bank   (rd_bank),
      .rd_slot   (rd_slot),
      .rd_vis    (rd_vis),
      .wr_en     (wr_en),
      .wr_bank   (wr_bank),
      .wr_slot   (wr_slot),
      .wr_vis    (wr_vis)
   );

   corr_vis_bank u_bank (
      .clk_x     (clk_x),
      .arst_n    (arst_n),
      .bank_sel  (bank_sel),
      .swap_now  (swap_now),
      .rd_en     (rd_en),
      .rd_bank   (rd_bank),
      .rd_slot   (rd_slot),
      .rd_vis    (rd_vis),
      .wr_en     (wr_en),
      .wr_bank   (wr_bank),
      .wr_slot   (wr_slot),
      .wr_vis    (wr_vis),
      .rb_slot   (rb_slot),
      .rb_vis    (rb_vis)
   );

   corr_readout u_readout (
      .clk_x     (clk_x),
      .arst_n    (arst_n),
      .bus_req   (bus_req),
      .bus_addr  (bus_addr),
      .bus_ack   (bus_ack),
      .bus_data  (bus_data),
      .rb_slot   (rb_slot),
      .rb_vis    (rb_vis)
   );

endmodule

/* tb_corr.sv */
`include "corr_cfg.svh"

module tb_corr;

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int HS_LIMIT     = 50;
   localparam int NUM_TESTS    = 6;
   localparam int WRAP_SAMPLES = 2100;
   // One slot pass plus the idle edge and some slack
   localparam int PASS_CYCLES  = `CORR_PAIRS + 2;
   localparam int WATCHDOG_TIME =
      NUM_TESTS * 2000 + WRAP_SAMPLES * PASS_CYCLES * CLK_PERIOD;

   logic              clk_x;
   logic              arst_n;
   logic              sample_en;
   corr_pkg::sample_t sample;
   logic              busy;
   logic              bank_swap;
   logic              bank_sel;
   logic              bus_req;
   corr_pkg::slot_t   bus_addr;
   logic              bus_ack;
   corr_pkg::vis_t    bus_data;

   // Expected contents of both banks
   corr_pkg::vis_t model_vis [2][`CORR_PAIRS];
   // Active bank as the model tracks it
   logic           exp_bank;
   int             mismatches;
   int             failures;
   int             seed;

   corr_top dut (
      .clk_x     (clk_x),
      .arst_n    (arst_n),
      .sample_en (sample_en),
      .sample    (sample),
      .busy      (busy),
      .bank_swap (bank_swap),
      .bank_sel  (bank_sel),
      .bus_req   (bus_req),
      .bus_addr  (bus_addr),
      .bus_ack   (bus_ack),
      .bus_data  (bus_data)
   );

   initial begin
      clk_x = 1'b0;
      forever #(CLK_PERIOD / 2) clk_x = ~clk_x;
   end

   // --------------------
   // Checks
   // --------------------

   task automatic check_vis(input string name, input corr_pkg::vis_t exp,
                            input corr_pkg::vis_t act);
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_failure(input string msg);
      failures++;
      $display("ERROR at time %0t: %s", $time, msg);
   endtask

   // --------------------
   // Reference model
   // --------------------

   // Table entry k, b index in the upper 5 bits, a in the lower 5
   task automatic table_pair(input int k, output int a, output int b);
      logic [10*`CORR_PAIRS-1:0] tbl;
      logic [9:0]                entry;
      tbl   = `CORR_PAIR_TABLE;
      entry = tbl[10*k +: 10];
      a     = int'(entry[4:0]);
      b     = int'(entry[9:5]);
   endtask

   // Equal bits count +1, unequal -1, wrapping at 12 bits
   task automatic model_add(input corr_pkg::sample_t s, input logic bank);
      int a;
      int b;
      int k;
      for (k = 0; k < `CORR_PAIRS; k++) begin
         table_pair(k, a, b);
         if (s.re[a] == s.re[b])
            model_vis[bank][k].cos_acc = model_vis[bank][k].cos_acc + corr_pkg::acc_t'(1);
         else
            model_vis[bank][k].cos_acc = model_vis[bank][k].cos_acc - corr_pkg::acc_t'(1);
         if (s.re[a] == s.im[b])
            model_vis[bank][k].sin_acc = model_vis[bank][k].sin_acc + corr_pkg::acc_t'(1);
         else
            model_vis[bank][k].sin_acc = model_vis[bank][k].sin_acc - corr_pkg::acc_t'(1);
      end
   endtask

   task automatic model_clear(input logic bank);
      int k;
      for (k = 0; k < `CORR_PAIRS; k++) begin
         model_vis[bank][k] = '0;
      end
   endtask

   function automatic corr_pkg::sample_t random_sample();
      corr_pkg::sample_t s;
      logic [31:0]       r;
      r    = $random(seed);
      s.re = r[`CORR_ANTENNAS-1:0];
      r    = $random(seed);
      s.im = r[`CORR_ANTENNAS-1:0];
      return s;
   endfunction

   // --------------------
   // Drivers
   // --------------------

   // Inputs change a little after the rising edge
   task automatic next_cycle();
      @(posedge clk_x);
      #DRIVE_DELAY;
   endtask

   task automatic send_sample(input corr_pkg::sample_t s);
      int waited;
      waited = 0;
      while (busy && waited < HS_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (busy) begin
         report_failure("busy stayed high, sample was not sent");
      end else begin
         sample    = s;
         sample_en = 1'b1;
         model_add(s, exp_bank);
         next_cycle();
         sample_en = 1'b0;
      end
   endtask

   // New active bank starts from zero
   task automatic wait_swap();
      int waited;
      waited = 0;
      while (bank_sel == exp_bank && waited < HS_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (bank_sel == exp_bank) begin
         report_failure("bank_sel did not change after a swap request");
      end else begin
         exp_bank = ~exp_bank;
         model_clear(exp_bank);
      end
   endtask

   task automatic do_swap();
      bank_swap = 1'b1;
      next_cycle();
      bank_swap = 1'b0;
      wait_swap();
   endtask

   // Full four-phase cycle, ack held for extra cycles when asked
   task automatic bus_read(input corr_pkg::slot_t addr, input int hold,
                           output corr_pkg::vis_t data);
      int waited;
      int i;
      data     = '0;
      bus_addr = addr;
      bus_req  = 1'b1;
      waited   = 0;
      next_cycle();
      while (!bus_ack && waited < HS_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (!bus_ack) begin
         report_failure("bus_ack did not rise after bus_req");
         bus_req = 1'b0;
      end else begin
         data = bus_data;
         for (i = 0; i < hold; i++) begin
            next_cycle();
            check_bit("bus_ack", 1'b1, bus_ack);
            check_vis("bus_data", data, bus_data);
         end
         bus_req = 1'b0;
         waited  = 0;
         next_cycle();
         while (bus_ack && waited < HS_LIMIT) begin
            next_cycle();
            waited++;
         end
         if (bus_ack) begin
            report_failure("bus_ack did not fall after bus_req dropped");
         end
      end
   endtask

   // All pairs of the bank not being accumulated
   task automatic check_idle_bank();
      corr_pkg::vis_t v;
      int             k;
      for (k = 0; k < `CORR_PAIRS; k++) begin
         bus_read(corr_pkg::slot_t'(k), 0, v);
         check_vis($sformatf("bus_data[%0d]", k), model_vis[~exp_bank][k], v);
      end
   endtask

   // --------------------
   // Tests
   // --------------------

   task automatic test_reset();
      check_bit("busy", 1'b0, busy);
      check_bit("bus_ack", 1'b0, bus_ack);
      check_bit("bank_sel", 1'b0, bank_sel);
      check_idle_bank();
   endtask

   // re words from the antenna index bits give every pair an unequal cos once
   task automatic test_accumulate();
      corr_pkg::sample_t s;
      s.re = '0;
      s.im = '0;
      send_sample(s);
      s.im = '1;
      send_sample(s);
      s    = random_sample();
      s.re = 24'hAA_AAAA;
      send_sample(s);
      s    = random_sample();
      s.re = 24'hCC_CCCC;
      send_sample(s);
      s    = random_sample();
      s.re = 24'hF0_F0F0;
      send_sample(s);
      do_swap();
      check_idle_bank();
   endtask

   task automatic test_bank_clear();
      repeat (3) send_sample(random_sample());
      do_swap();
      check_idle_bank();
      // Bank of the previous test comes back into use here
      repeat (2) send_sample(random_sample());
      do_swap();
      check_idle_bank();
   endtask

   task automatic test_swap_while_busy();
      send_sample(random_sample());
      check_bit("busy", 1'b1, busy);
      // Strobe and swap pulse together in the middle of the pass
      sample    = random_sample();
      sample_en = 1'b1;
      bank_swap = 1'b1;
      next_cycle();
      sample_en = 1'b0;
      bank_swap = 1'b0;
      check_bit("bank_sel", exp_bank, bank_sel);
      check_bit("busy", 1'b1, busy);
      wait_swap();
      check_idle_bank();
   endtask

   task automatic test_bus_protocol();
      corr_pkg::vis_t v;
      corr_pkg::vis_t exp_v;
      exp_v = model_vis[~exp_bank][3];
      // Swap during the held ack so the idle bank changes under the data
      fork
         bus_read(corr_pkg::slot_t'(3), 4, v);
         begin
            next_cycle();
            do_swap();
         end
      join
      check_vis("bus_data[3]", exp_v, v);
      // Out of range address
      bus_read(corr_pkg::slot_t'(12), 3, v);
      check_vis("bus_data[12]", '0, v);
   endtask

   task automatic test_wraparound();
      corr_pkg::sample_t s;
      s.re = '1;
      s.im = '1;
      repeat (WRAP_SAMPLES) send_sample(s);
      do_swap();
      check_idle_bank();
   endtask

   // --------------------
   // Main sequence
   // --------------------

   initial begin
      seed       = 32'h9122_1a81;
      mismatches = 0;
      failures   = 0;
      exp_bank   = 1'b0;
      arst_n     = 1'b0;
      sample_en  = 1'b0;
      sample     = '0;
      bank_swap  = 1'b0;
      bus_req    = 1'b0;
      bus_addr   = '0;
      model_clear(1'b0);
      model_clear(1'b1);
      repeat (4) @(posedge clk_x);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      next_cycle();
      test_reset();
      test_accumulate();
      test_bank_clear();
      test_swap_while_busy();
      test_bus_protocol();
      test_wraparound();
      $display("Done: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired after %0d time units, run did not finish", WATCHDOG_TIME);
      $display("Verification failed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
corr_pkg.sv
corr_sample_capture.sv
corr_pair_mac.sv
corr_vis_bank.sv
corr_readout.sv
corr_top.sv
tb_corr.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_corr
FILELIST = tb.f
OBJ_DIR  = obj_dir
PASS_MSG = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
